/* logic/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] xlen_t;   // addresses, fetch beats, immediates
  typedef logic [ILEN-1:0] inst_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_MISC_MEM  = 7'b0001111,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    CLASS_LOAD,
    CLASS_MISC_MEM,
    CLASS_OP_IMM,
    CLASS_AUIPC,
    CLASS_OP_IMM_32,
    CLASS_STORE,
    CLASS_OP,
    CLASS_LUI,
    CLASS_OP_32,
    CLASS_BRANCH,
    CLASS_JALR,
    CLASS_JAL,
    CLASS_SYSTEM,
    CLASS_ILLEGAL
  } inst_class_t;

  // funct7 values accepted for reg-reg ops
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;   // sub, sra
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // funct3 values that the decoder rejects
  localparam funct3_t F3_JALR     = 3'b000;
  localparam funct3_t F3_LOAD_BAD = 3'b111;
  localparam funct3_t F3_SYS_BAD  = 3'b100;

  // one burst is 8 beats of 8 bytes
  localparam int unsigned BURST_BEATS = 8;
  localparam int unsigned BURST_BYTES = 64;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  rv_pkg::xlen_t               entry,
  output rv_pkg::xlen_t               ar_addr,
  output logic                        ar_valid,
  input  logic                        ar_ready,
  input  rv_pkg::xlen_t               r_data,
  input  logic                        r_last,
  input  logic                        r_valid,
  output logic                        r_ready,
  output logic                        push,
  output rv_pkg::xlen_t               push_data,
  input  logic [$clog2(QUEUE_DEPTH):0] free_count
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_t;

  state_t state;
  rv_pkg::xlen_t fetch_addr;
  logic room;
  logic r_fire;

  // free_count lags a push by one cycle, so hold off while one is pending
  assign room = !push && (free_count >= rv_pkg::BURST_BEATS);
  assign r_fire = r_valid && r_ready;
  assign ar_addr = fetch_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      fetch_addr <= entry;
      ar_valid <= 1'b0;
      r_ready <= 1'b0;
      push <= 1'b0;
    end else begin
      push <= r_fire;   // beat goes to the queue one cycle later
      case (state)
        IDLE: begin
          if (room) begin
            ar_valid <= 1'b1;
            state <= ADDR;
          end
        end
        ADDR: begin
          if (ar_ready) begin   // address taken
            ar_valid <= 1'b0;
            r_ready <= 1'b1;
            fetch_addr <= fetch_addr + rv_pkg::xlen_t'(rv_pkg::BURST_BYTES);
            state <= DATA;
          end
        end
        DATA: begin
          if (r_fire && r_last) begin
            r_ready <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (r_fire) push_data <= r_data;
  end

  // AXI: address must not move while waiting for ready
  ar_addr_stable: assert property (@(posedge clk) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else $error("ar_addr changed before ar_ready");

  // bursts are incrementing from a 64-byte boundary
  entry_aligned: assert property (@(posedge clk)
    $fell(reset) |-> entry % rv_pkg::BURST_BYTES == 0)
    else $error("entry not 64-byte aligned");

endmodule

/* logic/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        push,
  input  rv_pkg::xlen_t               push_data,
  input  logic                        pop,
  output rv_pkg::xlen_t               head_data,
  output logic                        empty,
  output logic [$clog2(QUEUE_DEPTH):0] free_count
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  rv_pkg::xlen_t mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;   // occupied slots

  assign head_data = mem[rd_ptr];
  assign empty = (count == '0);
  assign free_count = (PTR_W + 1)'(QUEUE_DEPTH) - count;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;   // none or both
      endcase
    end
  end

  // fetch unit must only start a burst with room for all of it
  no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> count < (PTR_W + 1)'(QUEUE_DEPTH))
    else $error("push into full queue");

  no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> count != '0)
    else $error("pop from empty queue");

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic                clk,
  input  logic                reset,
  input  rv_pkg::xlen_t       entry,
  input  logic                empty,
  input  rv_pkg::xlen_t       head_data,
  output logic                pop,
  output logic                dec_valid,
  output rv_pkg::xlen_t       dec_pc,
  output rv_pkg::inst_class_t dec_class,
  output rv_pkg::reg_idx_t    dec_rd,
  output rv_pkg::reg_idx_t    dec_rs1,
  output rv_pkg::reg_idx_t    dec_rs2,
  output logic                dec_rd_en,
  output logic                dec_rs1_en,
  output logic                dec_rs2_en,
  output rv_pkg::xlen_t       dec_imm,
  output rv_pkg::funct3_t     dec_funct3
);

  typedef enum logic {
    LOW,
    HIGH
  } phase_t;

  phase_t phase;
  rv_pkg::inst_t hi_inst;   // upper half of the popped beat
  rv_pkg::xlen_t pc;
  rv_pkg::inst_t inst;
  logic fire;

  rv_pkg::opcode_t opc;
  rv_pkg::funct3_t f3;
  logic [6:0] f7;
  rv_pkg::xlen_t imm_i;
  rv_pkg::xlen_t imm_s;
  rv_pkg::xlen_t imm_b;
  rv_pkg::xlen_t imm_u;
  rv_pkg::xlen_t imm_j;
  rv_pkg::xlen_t imm;
  rv_pkg::inst_class_t cls;
  logic illegal;
  logic rd_en;
  logic rs1_en;
  logic rs2_en;

  assign pop = (phase == LOW) && !empty;
  assign fire = pop || (phase == HIGH);
  assign inst = (phase == LOW) ? head_data[31:0] : hi_inst;   // low word decodes first

  assign opc = rv_pkg::opcode_t'(inst[6:0]);
  assign f3 = inst[14:12];
  assign f7 = inst[31:25];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    illegal = 1'b0;
    imm = '0;
    cls = rv_pkg::CLASS_ILLEGAL;
    case (opc)
      rv_pkg::OPC_LOAD: begin
        cls = rv_pkg::CLASS_LOAD;
        imm = imm_i;
        illegal = (f3 == rv_pkg::F3_LOAD_BAD);
      end
      rv_pkg::OPC_MISC_MEM: cls = rv_pkg::CLASS_MISC_MEM;
      rv_pkg::OPC_OP_IMM: begin
        cls = rv_pkg::CLASS_OP_IMM;
        imm = imm_i;
      end
      rv_pkg::OPC_AUIPC: begin
        cls = rv_pkg::CLASS_AUIPC;
        imm = imm_u;
      end
      rv_pkg::OPC_OP_IMM_32: begin
        cls = rv_pkg::CLASS_OP_IMM_32;
        imm = imm_i;
      end
      rv_pkg::OPC_STORE: begin
        cls = rv_pkg::CLASS_STORE;
        imm = imm_s;
        illegal = f3[2];   // only sb/sh/sw/sd
      end
      rv_pkg::OPC_OP, rv_pkg::OPC_OP_32: begin
        cls = (opc == rv_pkg::OPC_OP) ? rv_pkg::CLASS_OP : rv_pkg::CLASS_OP_32;
        illegal = !(f7 inside {rv_pkg::F7_BASE, rv_pkg::F7_ALT, rv_pkg::F7_MULDIV});
      end
      rv_pkg::OPC_LUI: begin
        cls = rv_pkg::CLASS_LUI;
        imm = imm_u;
      end
      rv_pkg::OPC_BRANCH: begin
        cls = rv_pkg::CLASS_BRANCH;
        imm = imm_b;
        illegal = (f3 inside {3'b010, 3'b011});
      end
      rv_pkg::OPC_JALR: begin
        cls = rv_pkg::CLASS_JALR;
        imm = imm_i;
        illegal = (f3 != rv_pkg::F3_JALR);
      end
      rv_pkg::OPC_JAL: begin
        cls = rv_pkg::CLASS_JAL;
        imm = imm_j;
      end
      rv_pkg::OPC_SYSTEM: begin
        cls = rv_pkg::CLASS_SYSTEM;
        imm = imm_i;
        illegal = (f3 == rv_pkg::F3_SYS_BAD);
      end
      default: illegal = 1'b1;   // opcode not supported
    endcase
    if (illegal) cls = rv_pkg::CLASS_ILLEGAL;
  end

  // illegal falls out of every enable below
  assign rd_en = !(cls inside {rv_pkg::CLASS_BRANCH, rv_pkg::CLASS_STORE,
                               rv_pkg::CLASS_MISC_MEM, rv_pkg::CLASS_ILLEGAL});
  assign rs1_en = !(cls inside {rv_pkg::CLASS_LUI, rv_pkg::CLASS_AUIPC,
                                rv_pkg::CLASS_JAL, rv_pkg::CLASS_ILLEGAL});
  assign rs2_en = cls inside {rv_pkg::CLASS_BRANCH, rv_pkg::CLASS_STORE,
                              rv_pkg::CLASS_OP, rv_pkg::CLASS_OP_32};

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= LOW;
      pc <= entry;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fire;
      if (fire) pc <= pc + 64'd4;
      if (pop) phase <= HIGH;
      else if (phase == HIGH) phase <= LOW;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) hi_inst <= head_data[63:32];
    if (fire) begin
      dec_pc <= pc;
      dec_class <= cls;
      dec_rd <= inst[11:7];
      dec_rs1 <= inst[19:15];
      dec_rs2 <= inst[24:20];
      dec_rd_en <= rd_en;
      dec_rs1_en <= rs1_en;
      dec_rs2_en <= rs2_en;
      dec_imm <= imm;
      dec_funct3 <= f3;
    end
  end

endmodule

/* logic/rv_fetch_decode.sv */
`timescale 1ns/1ps

module rv_fetch_decode #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  rv_pkg::xlen_t       entry,
  output rv_pkg::xlen_t       ar_addr,
  output logic                ar_valid,
  input  logic                ar_ready,
  input  rv_pkg::xlen_t       r_data,
  input  logic                r_last,
  input  logic                r_valid,
  output logic                r_ready,
  output logic                dec_valid,
  output rv_pkg::xlen_t       dec_pc,
  output rv_pkg::inst_class_t dec_class,
  output rv_pkg::reg_idx_t    dec_rd,
  output rv_pkg::reg_idx_t    dec_rs1,
  output rv_pkg::reg_idx_t    dec_rs2,
  output logic                dec_rd_en,
  output logic                dec_rs1_en,
  output logic                dec_rs2_en,
  output rv_pkg::xlen_t       dec_imm,
  output rv_pkg::funct3_t     dec_funct3
);

  logic push;
  rv_pkg::xlen_t push_data;
  logic pop;
  logic empty;
  rv_pkg::xlen_t head_data;
  logic [$clog2(QUEUE_DEPTH):0] free_count;

  fetch_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry),
    .ar_addr    (ar_addr),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r_data     (r_data),
    .r_last     (r_last),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .push       (push),
    .push_data  (push_data),
    .free_count (free_count)
  );

  inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .head_data  (head_data),
    .empty      (empty),
    .free_count (free_count)
  );

  inst_decoder u_dec (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry),
    .empty      (empty),
    .head_data  (head_data),
    .pop        (pop),
    .dec_valid  (dec_valid),
    .dec_pc     (dec_pc),
    .dec_class  (dec_class),
    .dec_rd     (dec_rd),
    .dec_rs1    (dec_rs1),
    .dec_rs2    (dec_rs2),
    .dec_rd_en  (dec_rd_en),
    .dec_rs1_en (dec_rs1_en),
    .dec_rs2_en (dec_rs2_en),
    .dec_imm    (dec_imm),
    .dec_funct3 (dec_funct3)
  );

endmodule

/* test/tb_mem_responder.sv */
`timescale 1ns/1ps

module tb_mem_responder (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall_en,
  input  rv_pkg::xlen_t ar_addr,
  input  logic          ar_valid,
  output logic          ar_ready,
  output rv_pkg::xlen_t r_data,
  output logic          r_last,
  output logic          r_valid,
  input  logic          r_ready
);

  // 256 beats of 8 bytes, the address wraps at 2 KB
  rv_pkg::xlen_t mem [256];

  integer seed = 32'h7a5d_7688;
  logic busy;
  rv_pkg::xlen_t burst_addr;
  logic [3:0] beat;   // beat on the bus or next to send

  always @(posedge clk) begin
    logic [3:0] nb;
    logic go;
    logic [7:0] idx;
    go = !stall_en || (($random(seed) & 3) != 0);
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid <= 1'b0;
      r_last <= 1'b0;
      r_data <= '0;
      busy <= 1'b0;
      beat <= '0;
    end else if (!busy) begin
      if (ar_valid && ar_ready) begin
        busy <= 1'b1;
        burst_addr <= ar_addr;
        beat <= '0;
        ar_ready <= 1'b0;
      end else begin
        ar_ready <= go;
      end
    end else if (r_valid && r_ready && r_last) begin
      busy <= 1'b0;
      r_valid <= 1'b0;
      r_last <= 1'b0;
    end else if (!r_valid || r_ready) begin
      nb = r_valid ? beat + 4'd1 : beat;   // step on once the beat is taken
      idx = burst_addr[10:3] + 8'(nb);
      beat <= nb;
      r_valid <= go;
      r_data <= mem[idx];
      r_last <= (nb == 4'(rv_pkg::BURST_BEATS - 1));
    end
  end

endmodule

/* include/tb_inst_enc.svh */
`ifndef TB_INST_ENC_SVH
`define TB_INST_ENC_SVH

// opcode is a raw 7-bit value so unsupported encodings can be built too
function automatic rv_pkg::inst_t enc_r(input logic [6:0] opc, input rv_pkg::reg_idx_t rd,
    input rv_pkg::funct3_t f3, input rv_pkg::reg_idx_t rs1, input rv_pkg::reg_idx_t rs2,
    input logic [6:0] f7);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::inst_t enc_i(input logic [6:0] opc, input rv_pkg::reg_idx_t rd,
    input rv_pkg::funct3_t f3, input rv_pkg::reg_idx_t rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::inst_t enc_s(input rv_pkg::funct3_t f3, input rv_pkg::reg_idx_t rs1,
    input rv_pkg::reg_idx_t rs2, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic rv_pkg::inst_t enc_b(input rv_pkg::funct3_t f3, input rv_pkg::reg_idx_t rs1,
    input rv_pkg::reg_idx_t rs2, input logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic rv_pkg::inst_t enc_u(input logic [6:0] opc, input rv_pkg::reg_idx_t rd,
    input logic [19:0] imm);
  return {imm, rd, opc};   // imm is bits 31:12
endfunction

function automatic rv_pkg::inst_t enc_j(input rv_pkg::reg_idx_t rd, input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
endfunction

`endif

/* test/tb_rv_fetch_decode.sv */
`timescale 1ns/1ps

module tb_rv_fetch_decode;

  `include "tb_inst_enc.svh"

  localparam int MAX_CYCLES = 4000;   // six tests, up to 64 instructions each, with stalls

  logic clk = 1'b0;
  logic reset;
  logic stall_en;
  rv_pkg::xlen_t entry;
  rv_pkg::xlen_t ar_addr;
  logic ar_valid;
  logic ar_ready;
  rv_pkg::xlen_t r_data;
  logic r_last;
  logic r_valid;
  logic r_ready;
  logic dec_valid;
  rv_pkg::xlen_t dec_pc;
  rv_pkg::inst_class_t dec_class;
  rv_pkg::reg_idx_t dec_rd;
  rv_pkg::reg_idx_t dec_rs1;
  rv_pkg::reg_idx_t dec_rs2;
  logic dec_rd_en;
  logic dec_rs1_en;
  logic dec_rs2_en;
  rv_pkg::xlen_t dec_imm;
  rv_pkg::funct3_t dec_funct3;

  integer seed = 32'h7a5d_7688;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int cycles = 0;

  // expected program
  rv_pkg::inst_t exp_inst [$];
  rv_pkg::inst_class_t exp_cls [$];
  rv_pkg::xlen_t exp_imm [$];
  logic [2:0] exp_en [$];   // rd, rs1, rs2

  // observed decode stream and bus addresses
  rv_pkg::xlen_t got_pc [$];
  rv_pkg::xlen_t got_ar [$];
  logic [127:0] got_rec [$];
  logic [127:0] saved_rec [$];

  rv_fetch_decode #(.QUEUE_DEPTH(16)) u_dut (
    .clk(clk), .reset(reset), .entry(entry),
    .ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r_data(r_data), .r_last(r_last), .r_valid(r_valid), .r_ready(r_ready),
    .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_class(dec_class),
    .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
    .dec_rd_en(dec_rd_en), .dec_rs1_en(dec_rs1_en), .dec_rs2_en(dec_rs2_en),
    .dec_imm(dec_imm), .dec_funct3(dec_funct3)
  );

  tb_mem_responder u_mem (
    .clk(clk), .reset(reset), .stall_en(stall_en),
    .ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r_data(r_data), .r_last(r_last), .r_valid(r_valid), .r_ready(r_ready)
  );

  always #10 clk = !clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (!reset && ar_valid && ar_ready) got_ar.push_back(ar_addr);
    if (!reset && dec_valid) begin
      got_pc.push_back(dec_pc);
      got_rec.push_back({dec_imm, dec_class, dec_rd, dec_rs1, dec_rs2,
                         dec_funct3, dec_rd_en, dec_rs1_en, dec_rs2_en, 39'h0});
    end
  end

  function automatic rv_pkg::xlen_t sext(input logic [31:0] v, input int bits);
    return rv_pkg::xlen_t'($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  task automatic add_inst(input rv_pkg::inst_t i, input rv_pkg::inst_class_t c,
      input rv_pkg::xlen_t imm, input logic [2:0] en);
    exp_inst.push_back(i);
    exp_cls.push_back(c);
    exp_imm.push_back(imm);
    exp_en.push_back(en);
  endtask

  task automatic clear_prog();
    exp_inst.delete();
    exp_cls.delete();
    exp_imm.delete();
    exp_en.delete();
  endtask

  task automatic run_prog(input rv_pkg::xlen_t start, input logic stall);
    int n;
    n = exp_inst.size();
    for (int a = 0; a < 256; a++) begin
      u_mem.mem[a] = {enc_i(7'h13, a[4:0], 3'd0, a[7:3], 12'(a)), 32'h0000_0013};
    end
    for (int i = 0; i < n; i++) begin
      if (i % 2 == 0) u_mem.mem[8'(start[10:3] + i / 2)][31:0] = exp_inst[i];
      else u_mem.mem[8'(start[10:3] + i / 2)][63:32] = exp_inst[i];
    end
    reset <= 1'b1;
    entry <= start;
    stall_en <= stall;
    for (int c = 0; c < 16; c++) begin
      @(posedge clk);
      // first edge still shows the previous run
      if (c > 0 && (ar_valid || r_ready || dec_valid)) begin
        $display("mismatch at %0t: bus or decode output active during reset", $time);
        errors++;
      end
    end
    got_pc.delete();
    got_ar.delete();
    got_rec.delete();
    reset <= 1'b0;
    @(posedge clk);
    if (ar_valid || r_ready || dec_valid) begin
      $display("mismatch at %0t: bus or decode output active right after reset", $time);
      errors++;
    end
    while (got_pc.size() < n) @(posedge clk);
    if (got_ar.size() == 0 || got_ar[0] != start) begin
      $display("mismatch at %0t: first ar_addr is not entry %h", $time, start);
      errors++;
    end
    for (int j = 1; j < got_ar.size(); j++) begin
      if (got_ar[j] != got_ar[j-1] + 64) begin
        $display("mismatch at %0t: burst %0d addr %h", $time, j, got_ar[j]);
        errors++;
      end
    end
  endtask

  task automatic check_stream(input rv_pkg::xlen_t start);
    rv_pkg::inst_t i;
    logic [127:0] r;
    for (int k = 0; k < exp_inst.size(); k++) begin
      i = exp_inst[k];
      r = {exp_imm[k], exp_cls[k], i[11:7], i[19:15], i[24:20], i[14:12],
           exp_en[k], 39'h0};
      if (got_pc[k] != start + 4 * k) begin
        $display("mismatch at %0t: pc %h, expected %h", $time, got_pc[k], start + 4 * k);
        errors++;
      end
      if (got_rec[k] != r) begin
        $display("mismatch at %0t: inst %0d (%h) got %h expected %h",
                 $time, k, i, got_rec[k], r);
        errors++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors != err_before) failed_tests++;
    $display("test %s: %s", name, (errors == err_before) ? "pass" : "fail");
  endtask

  task automatic test_reset_first_addr();
    int e;
    e = errors;
    clear_prog();
    for (int k = 0; k < 16; k++) begin
      add_inst(enc_i(7'h13, 5'(k), 3'd0, 5'd1, 12'(k)), rv_pkg::CLASS_OP_IMM, 64'(k), 3'b110);
    end
    run_prog(64'h8000_0040, 1'b0);
    finish_test("reset_first_addr", e);
  endtask

  task automatic test_in_order();
    int e;
    e = errors;
    clear_prog();
    for (int k = 0; k < 32; k++) begin
      add_inst(enc_r(7'h33, 5'(k), 3'd0, 5'(k + 1), 5'(k + 2), 7'h00),
               rv_pkg::CLASS_OP, 64'd0, 3'b111);
    end
    run_prog(64'h8000_0000, 1'b0);
    check_stream(64'h8000_0000);
    finish_test("in_order", e);
  endtask

  task automatic test_immediates();
    int e;
    e = errors;
    clear_prog();
    add_inst(enc_i(7'h13, 5'd1, 3'd0, 5'd2, 12'h07f), rv_pkg::CLASS_OP_IMM, 64'h7f, 3'b110);
    add_inst(enc_i(7'h03, 5'd1, 3'd3, 5'd2, 12'h800), rv_pkg::CLASS_LOAD,
             sext(32'h800, 12), 3'b110);
    add_inst(enc_s(3'd3, 5'd2, 5'd3, 12'h155), rv_pkg::CLASS_STORE, 64'h155, 3'b011);
    add_inst(enc_s(3'd2, 5'd2, 5'd3, 12'hff8), rv_pkg::CLASS_STORE,
             sext(32'hff8, 12), 3'b011);
    add_inst(enc_b(3'd0, 5'd4, 5'd5, 13'h0a4), rv_pkg::CLASS_BRANCH, 64'ha4, 3'b011);
    add_inst(enc_b(3'd1, 5'd4, 5'd5, 13'h1ffc), rv_pkg::CLASS_BRANCH,
             sext(32'h1ffc, 13), 3'b011);
    add_inst(enc_u(7'h37, 5'd6, 20'h12345), rv_pkg::CLASS_LUI, 64'h1234_5000, 3'b100);
    add_inst(enc_u(7'h17, 5'd6, 20'hfedcb), rv_pkg::CLASS_AUIPC,
             sext(32'hfedc_b000, 32), 3'b100);
    add_inst(enc_j(5'd1, 21'h0_4a6c), rv_pkg::CLASS_JAL, 64'h4a6c, 3'b100);
    add_inst(enc_j(5'd1, 21'h1f_fff0), rv_pkg::CLASS_JAL, sext(32'h1f_fff0, 21), 3'b100);
    run_prog(64'h8000_0100, 1'b0);
    check_stream(64'h8000_0100);
    finish_test("immediates", e);
  endtask

  task automatic test_reg_fields();
    int e;
    e = errors;
    clear_prog();
    add_inst(enc_u(7'h37, 5'd10, 20'h00abc), rv_pkg::CLASS_LUI, 64'hab_c000, 3'b100);
    add_inst(enc_s(3'd3, 5'd11, 5'd12, 12'h010), rv_pkg::CLASS_STORE, 64'h10, 3'b011);
    add_inst(enc_b(3'd0, 5'd13, 5'd14, 13'h008), rv_pkg::CLASS_BRANCH, 64'h8, 3'b011);
    add_inst(enc_r(7'h33, 5'd15, 3'd0, 5'd16, 5'd17, 7'h00), rv_pkg::CLASS_OP, 0, 3'b111);
    add_inst(enc_i(7'h67, 5'd1, 3'd0, 5'd18, 12'h004), rv_pkg::CLASS_JALR, 64'h4, 3'b110);
    add_inst(enc_i(7'h03, 5'd19, 3'd3, 5'd20, 12'h020), rv_pkg::CLASS_LOAD, 64'h20, 3'b110);
    run_prog(64'h8000_0200, 1'b0);
    check_stream(64'h8000_0200);
    finish_test("reg_fields", e);
  endtask

  task automatic test_illegal();
    int e;
    e = errors;
    clear_prog();
    // immediate still follows the opcode's format
    add_inst(enc_i(7'h7f, 5'd1, 3'd0, 5'd2, 12'h0), rv_pkg::CLASS_ILLEGAL, 0, 3'b000);
    add_inst(enc_i(7'h67, 5'd1, 3'd1, 5'd2, 12'h4), rv_pkg::CLASS_ILLEGAL, 64'h4, 3'b000);
    add_inst(enc_b(3'd2, 5'd1, 5'd2, 13'h8), rv_pkg::CLASS_ILLEGAL, 64'h8, 3'b000);
    add_inst(enc_b(3'd3, 5'd1, 5'd2, 13'h8), rv_pkg::CLASS_ILLEGAL, 64'h8, 3'b000);
    add_inst(enc_i(7'h03, 5'd1, 3'd7, 5'd2, 12'h8), rv_pkg::CLASS_ILLEGAL, 64'h8, 3'b000);
    add_inst(enc_s(3'd4, 5'd1, 5'd2, 12'h8), rv_pkg::CLASS_ILLEGAL, 64'h8, 3'b000);
    add_inst(enc_r(7'h33, 5'd1, 3'd0, 5'd2, 5'd3, 7'h02), rv_pkg::CLASS_ILLEGAL, 0, 3'b000);
    add_inst(enc_r(7'h3b, 5'd1, 3'd0, 5'd2, 5'd3, 7'h40 | 7'h10), rv_pkg::CLASS_ILLEGAL,
             0, 3'b000);
    add_inst(enc_i(7'h73, 5'd1, 3'd4, 5'd2, 12'h0), rv_pkg::CLASS_ILLEGAL, 0, 3'b000);
    add_inst(enc_i(7'h13, 5'd0, 3'd0, 5'd0, 12'h0), rv_pkg::CLASS_OP_IMM, 0, 3'b110);
    run_prog(64'h8000_0300, 1'b0);
    check_stream(64'h8000_0300);
    finish_test("illegal", e);
  endtask

  task automatic test_stalls();
    int e;
    logic [31:0] r;
    e = errors;
    clear_prog();
    for (int k = 0; k < 64; k++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: add_inst(enc_i(7'h13, r[6:2], 3'd0, r[11:7], r[23:12]), rv_pkg::CLASS_OP_IMM,
                       sext(32'(r[23:12]), 12), 3'b110);
        2'd1: add_inst(enc_r(7'h33, r[6:2], 3'd0, r[11:7], r[16:12], 7'h20),
                       rv_pkg::CLASS_OP, 0, 3'b111);
        2'd2: add_inst(enc_s({1'b0, r[31:30]}, r[6:2], r[11:7], r[23:12]),
                       rv_pkg::CLASS_STORE, sext(32'(r[23:12]), 12), 3'b011);
        default: add_inst(enc_b(3'd0, r[6:2], r[11:7], {r[23:12], 1'b0}),
                          rv_pkg::CLASS_BRANCH, sext(32'({r[23:12], 1'b0}), 13), 3'b011);
      endcase
    end
    run_prog(64'h8000_0400, 1'b0);
    check_stream(64'h8000_0400);
    saved_rec = got_rec;
    run_prog(64'h8000_0400, 1'b1);
    for (int k = 0; k < 64; k++) begin
      if (got_rec[k] != saved_rec[k] || got_pc[k] != 64'h8000_0400 + 4 * k) begin
        $display("mismatch at %0t: stalled run differs at inst %0d", $time, k);
        errors++;
      end
    end
    finish_test("stalls", e);
  endtask

  initial begin
    reset = 1'b1;
    entry = 64'h8000_0000;
    stall_en = 1'b0;
    test_reset_first_addr();
    test_in_order();
    test_immediates();
    test_reg_fields();
    test_illegal();
    test_stalls();
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/inst_decoder.sv
logic/rv_fetch_decode.sv
test/tb_mem_responder.sv
test/tb_rv_fetch_decode.sv
